// File: Bender.yml
package:
  name: peripheralSubsystem

sources:
  - logic/socBusPkg.sv
  - logic/busDecodeStage.sv
  - logic/scratchRam.sv
  - logic/randomSource.sv
  - logic/intervalTimers.sv
  - logic/interruptController.sv
  - logic/responseStage.sv
  - logic/peripheralSubsystem.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verification/peripheralSubsystemTb.sv

// File: logic/busDecodeStage.sv
`timescale 1ns/1ps

module busDecodeStage (
    input   logic                   clk,
    input   logic                   rstN,
    input   socBusPkg::busReqT      busReq,
    output  socBusPkg::busReqT      stageReq,
    output  socBusPkg::targetSelT   targetSel
);

    // registered strobes
    logic                               reqRead;
    logic                               reqWrite;
    // registered payload
    logic [3:0]                         reqBwe;
    socBusPkg::busAddrT                 reqAddress;
    logic [socBusPkg::dataWidth-1:0]    reqData;
    // select for the incoming request
    socBusPkg::targetSelT               selNext;

    // region decode, only while a strobe is up
    always_comb begin
        selNext = '0;
        if (busReq.read || busReq.write) begin
            case (socBusPkg::regionT'(busReq.address.regView.region))
                socBusPkg::ramRegion:       selNext.ram = 1'b1;
                socBusPkg::randomRegion:    selNext.random = 1'b1;
                socBusPkg::timerRegion:     selNext.timer = 1'b1;
                // codes 3 to 15
                default:                    selNext.unmapped = 1'b1;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            reqRead <= 1'b0;
            reqWrite <= 1'b0;
            targetSel <= '0;
        end else begin
            reqRead <= busReq.read;
            reqWrite <= busReq.write;
            targetSel <= selNext;
        end
    end

    // payload taken every cycle, qualified by the strobes downstream
    always_ff @(posedge clk) begin
        reqBwe <= busReq.bwe;
        reqAddress <= busReq.address;
        reqData <= busReq.writeData;
    end

    always_comb begin
        stageReq.read = reqRead;
        stageReq.write = reqWrite;
        stageReq.bwe = reqBwe;
        stageReq.address = reqAddress;
        stageReq.writeData = reqData;
    end

endmodule

// File: logic/interruptController.sv
`timescale 1ns/1ps

module interruptController (
    input   logic                               clk,
    input   logic                               rstN,
    input   logic [socBusPkg::irqLines-1:0]     triggerInterrupt,
    input   logic                               interruptAcknowledge,
    input   logic [socBusPkg::irqIdWidth-1:0]   interruptIn,
    output  logic                               interruptRequest,
    output  logic [socBusPkg::irqIdWidth-1:0]   interruptOut
);

    // one latch per line
    logic [socBusPkg::irqLines-1:0] pending;
    // line named by the acknowledge
    logic [socBusPkg::irqLines-1:0] clearMask;

    always_comb begin
        clearMask = '0;
        if (interruptAcknowledge) begin
            clearMask[interruptIn] = 1'b1;
        end
    end

    // a new pulse wins over an acknowledge of the same line
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pending <= '0;
        end else begin
            pending <= (pending & ~clearMask) | triggerInterrupt;
        end
    end

    assign interruptRequest = |pending;

    // lowest pending line has priority
    // scan downward so the last hit is the lowest
    always_comb begin
        interruptOut = '0;
        for (int i = socBusPkg::irqLines - 1; i >= 0; i--) begin
            if (pending[i]) begin
                interruptOut = i[socBusPkg::irqIdWidth-1:0];
            end
        end
    end

endmodule

// File: logic/intervalTimers.sv
`timescale 1ns/1ps

module intervalTimers (
    input   logic                               clk,
    input   logic                               rstN,
    input   logic                               sel,
    input   socBusPkg::busReqT                  stageReq,
    output  socBusPkg::busRspT                  timerRsp,
    output  logic [socBusPkg::timerCount-1:0]   timerIrq
);

    // per timer reload value and live count
    logic [socBusPkg::dataWidth-1:0]    reload [socBusPkg::timerCount];
    logic [socBusPkg::dataWidth-1:0]    count [socBusPkg::timerCount];

    logic [socBusPkg::timerRegWidth-1:0] regIndex;
    logic                               timerWrite;
    logic                               readValid;
    logic [socBusPkg::dataWidth-1:0]    readData;

    assign regIndex = stageReq.address.regView.regIndex;
    assign timerWrite = sel && stageReq.write;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int k = 0; k < socBusPkg::timerCount; k++) begin
                reload[k] <= '0;
                count[k] <= '0;
            end
            timerIrq <= '0;
            readValid <= 1'b0;
        end else begin
            readValid <= sel && stageReq.read;
            for (int k = 0; k < socBusPkg::timerCount; k++) begin
                // pulse lasts one cycle
                timerIrq[k] <= 1'b0;
                if (timerWrite && (regIndex == k)) begin
                    // a write restarts the period, zero stops it
                    reload[k] <= stageReq.writeData;
                    count[k] <= stageReq.writeData;
                end else if (reload[k] != '0) begin
                    // would hit zero, so reload and fire
                    if (count[k] <= 1) begin
                        count[k] <= reload[k];
                        timerIrq[k] <= 1'b1;
                    end else begin
                        count[k] <= count[k] - 1'b1;
                    end
                end
            end
        end
    end

    // live count readback
    // indices past the bank read zero
    always_ff @(posedge clk) begin
        if (sel && stageReq.read) begin
            readData <= '0;
            for (int k = 0; k < socBusPkg::timerCount; k++) begin
                if (regIndex == k) begin
                    readData <= count[k];
                end
            end
        end
    end

    assign timerRsp = '{valid: readValid, data: readData};

endmodule

// File: logic/peripheralSubsystem.sv
`timescale 1ns/1ps

module peripheralSubsystem (
    input   logic                               clk,
    input   logic                               rstN,
    input   socBusPkg::busReqT                  busReq,
    output  socBusPkg::busRspT                  busRsp,
    input   logic                               interruptAcknowledge,
    input   logic [socBusPkg::irqIdWidth-1:0]   interruptIn,
    output  logic                               interruptRequest,
    output  logic [socBusPkg::irqIdWidth-1:0]   interruptOut
);

    // decode stage outputs
    socBusPkg::busReqT                  stageReq;
    socBusPkg::targetSelT               targetSel;

    // target responses
    socBusPkg::busRspT                  ramRsp;
    socBusPkg::busRspT                  randomRsp;
    socBusPkg::busRspT                  timerRsp;
    logic                               unmappedRead;

    // interrupt wires
    logic [socBusPkg::timerCount-1:0]   timerIrq;
    logic [socBusPkg::irqLines-1:0]     triggerInterrupt;

    // writes to unmapped space get no answer
    assign unmappedRead = targetSel.unmapped & stageReq.read;

    // timers from timerIrqBase upward, remaining lines unused
    always_comb begin
        triggerInterrupt = '0;
        triggerInterrupt[socBusPkg::timerIrqBase +: socBusPkg::timerCount] = timerIrq;
    end

    busDecodeStage
    busDecodeStage(
        .clk,
        .rstN,
        .busReq,
        .stageReq,
        .targetSel
    );

    scratchRam
    scratchRam(
        .clk,
        .rstN,
        .sel                    (targetSel.ram),
        .stageReq,
        .ramRsp
    );

    randomSource
    randomSource(
        .clk,
        .rstN,
        .sel                    (targetSel.random),
        .stageReq,
        .randomRsp
    );

    intervalTimers
    intervalTimers(
        .clk,
        .rstN,
        .sel                    (targetSel.timer),
        .stageReq,
        .timerRsp,
        .timerIrq
    );

    responseStage
    responseStage(
        .clk,
        .rstN,
        .ramRsp,
        .randomRsp,
        .timerRsp,
        .unmappedRead,
        .busRsp
    );

    interruptController
    interruptController(
        .clk,
        .rstN,
        .triggerInterrupt,
        .interruptAcknowledge,
        .interruptIn,
        .interruptRequest,
        .interruptOut
    );

endmodule

// File: logic/randomSource.sv
`timescale 1ns/1ps

module randomSource (
    input   logic                   clk,
    input   logic                   rstN,
    input   logic                   sel,
    input   socBusPkg::busReqT      stageReq,
    output  socBusPkg::busRspT      randomRsp
);

    logic [socBusPkg::dataWidth-1:0]    lfsrState;
    logic [socBusPkg::dataWidth-1:0]    lfsrNext;
    logic [socBusPkg::dataWidth-1:0]    readData;
    logic                               readValid;

    // galois step, taps folded in when a one drops out
    assign lfsrNext = {1'b0, lfsrState[socBusPkg::dataWidth-1:1]}
                    ^ (lfsrState[0] ? socBusPkg::lfsrTaps : '0);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            lfsrState <= socBusPkg::lfsrSeed;
            readValid <= 1'b0;
        end else begin
            readValid <= sel && stageReq.read;
            // zero would lock up the lfsr
            if (sel && stageReq.write) begin
                lfsrState <= (stageReq.writeData == '0) ? socBusPkg::lfsrSeed
                                                        : stageReq.writeData;
            end else if (sel && stageReq.read) begin
                lfsrState <= lfsrNext;
            end
        end
    end

    // value before the step goes out
    always_ff @(posedge clk) begin
        if (sel && stageReq.read) begin
            readData <= lfsrState;
        end
    end

    assign randomRsp = '{valid: readValid, data: readData};

endmodule

// File: logic/responseStage.sv
`timescale 1ns/1ps

module responseStage (
    input   logic                   clk,
    input   logic                   rstN,
    input   socBusPkg::busRspT      ramRsp,
    input   socBusPkg::busRspT      randomRsp,
    input   socBusPkg::busRspT      timerRsp,
    input   logic                   unmappedRead,
    output  socBusPkg::busRspT      busRsp
);

    // unmapped read delayed to line up with the target responses
    logic unmappedPending;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            unmappedPending <= 1'b0;
        end else begin
            unmappedPending <= unmappedRead;
        end
    end

    // only one source is valid per cycle
    // unmapped falls through to zero data
    always_comb begin
        busRsp.valid = ramRsp.valid | randomRsp.valid | timerRsp.valid | unmappedPending;
        busRsp.data = '0;
        if (ramRsp.valid) begin
            busRsp.data = ramRsp.data;
        end else if (randomRsp.valid) begin
            busRsp.data = randomRsp.data;
        end else if (timerRsp.valid) begin
            busRsp.data = timerRsp.data;
        end
    end

endmodule

// File: logic/scratchRam.sv
`timescale 1ns/1ps

module scratchRam (
    input   logic                   clk,
    input   logic                   rstN,
    input   logic                   sel,
    input   socBusPkg::busReqT      stageReq,
    output  socBusPkg::busRspT      ramRsp
);

    // word storage
    logic [socBusPkg::dataWidth-1:0]    mem [socBusPkg::ramWords];

    logic [socBusPkg::ramIndexWidth-1:0] wordIndex;
    logic                               readValid;
    logic [socBusPkg::dataWidth-1:0]    readData;

    // byte lane bits are ignored, word access only
    assign wordIndex = stageReq.address.ramView.wordIndex;

    // lane writes and registered read
    always_ff @(posedge clk) begin
        if (sel && stageReq.write) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (stageReq.bwe[lane]) begin
                    mem[wordIndex][lane*8 +: 8] <= stageReq.writeData[lane*8 +: 8];
                end
            end
        end
        if (sel && stageReq.read) begin
            readData <= mem[wordIndex];
        end
    end

    // one cycle read strobe
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            readValid <= 1'b0;
        end else begin
            readValid <= sel && stageReq.read;
        end
    end

    assign ramRsp = '{valid: readValid, data: readData};

endmodule

// File: logic/socBusPkg.sv
package socBusPkg;

    // bus data width
    localparam int dataWidth = 32;

    // scratch ram geometry
    localparam int ramWords = 4096;
    localparam int ramIndexWidth = 12;

    // timer bank
    localparam int timerCount = 3;
    localparam int timerRegWidth = 3;

    // interrupt controller
    localparam int irqLines = 16;
    localparam int irqIdWidth = 4;
    // line of the first timer, the others follow
    localparam int timerIrqBase = 0;

    // galois lfsr, shifts right
    localparam logic [dataWidth-1:0] lfsrTaps = 32'h80200003;
    localparam logic [dataWidth-1:0] lfsrSeed = 32'h00000001;

    // region codes at address bits 19:16, anything else is unmapped
    typedef enum logic [3:0] {
        ramRegion    = 4'd0,
        randomRegion = 4'd1,
        timerRegion  = 4'd2
    } regionT;

    // byte address as the ram sees it
    typedef struct packed {
        logic [11:0]                unused;
        logic [3:0]                 region;
        logic [13-ramIndexWidth:0]  spare;
        logic [ramIndexWidth-1:0]   wordIndex;
        logic [1:0]                 byteLane;
    } ramViewT;

    // same address as a register file sees it
    typedef struct packed {
        logic [11:0]                unused;
        logic [3:0]                 region;
        logic [13-timerRegWidth:0]  spare;
        logic [timerRegWidth-1:0]   regIndex;
        logic [1:0]                 byteLane;
    } regViewT;

    typedef union packed {
        ramViewT    ramView;
        regViewT    regView;
    } busAddrT;

    // one request from the master, 70 bits
    typedef struct packed {
        logic                   read;
        logic                   write;
        logic [3:0]             bwe;
        busAddrT                address;
        logic [dataWidth-1:0]   writeData;
    } busReqT;

    // one hot target select
    typedef struct packed {
        logic   ram;
        logic   random;
        logic   timer;
        logic   unmapped;
    } targetSelT;

    // read return, 33 bits
    typedef struct packed {
        logic                   valid;
        logic [dataWidth-1:0]   data;
    } busRspT;

endpackage

// File: peripheralSubsystem.f
+incdir+include
logic/socBusPkg.sv
logic/busDecodeStage.sv
logic/scratchRam.sv
logic/randomSource.sv
logic/intervalTimers.sv
logic/interruptController.sv
logic/responseStage.sv
logic/peripheralSubsystem.sv
verification/peripheralSubsystemTb.sv

// File: include/tbBusTasks.svh
`ifndef TB_BUS_TASKS_SVH
`define TB_BUS_TASKS_SVH

// expected read data, oldest at the front
logic [31:0] expectedReads [$];

// reference step of the random source lfsr
function automatic logic [31:0] lfsrStep(input logic [31:0] state);
    return {1'b0, state[31:1]} ^ (state[0] ? socBusPkg::lfsrTaps : 32'h0);
endfunction

// index lands on bits 13:2, so it also serves as a timer register index
function automatic socBusPkg::busAddrT regionAddress(input logic [3:0] region,
                                                     input logic [11:0] index);
    socBusPkg::busAddrT addr;
    addr = '0;
    addr.ramView.region = region;
    addr.ramView.wordIndex = index;
    return addr;
endfunction

// each task drives one cycle, the request stays until the next call
task automatic busIdle();
    @(posedge clk);
    #1;
    busReq = '0;
endtask

task automatic busWrite(input socBusPkg::busAddrT addr, input logic [31:0] data,
                        input logic [3:0] bwe);
    @(posedge clk);
    #1;
    busReq = '0;
    busReq.write = 1'b1;
    busReq.bwe = bwe;
    busReq.address = addr;
    busReq.writeData = data;
endtask

// queues the value the response must carry
task automatic busRead(input socBusPkg::busAddrT addr, input logic [31:0] expected);
    @(posedge clk);
    #1;
    busReq = '0;
    busReq.read = 1'b1;
    busReq.address = addr;
    expectedReads.push_back(expected);
endtask

// one cycle acknowledge pulse
task automatic ackInterrupt(input logic [3:0] id);
    @(posedge clk);
    #1;
    interruptAcknowledge = 1'b1;
    interruptIn = id;
    @(posedge clk);
    #1;
    interruptAcknowledge = 1'b0;
endtask

`endif

// File: verification/peripheralSubsystemTb.sv
`timescale 1ns/1ps

module peripheralSubsystemTb;

    logic                   clk;
    logic                   rstN;
    socBusPkg::busReqT      busReq;
    socBusPkg::busRspT      busRsp;
    logic                   interruptAcknowledge;
    logic [3:0]             interruptIn;
    logic                   interruptRequest;
    logic [3:0]             interruptOut;

    integer         seed;
    int             cycleCount = 0;
    // ram contents as the master expects them
    logic [31:0]    ramModel [4096];
    int             ramIndices [$];

    `include "tbBusTasks.svh"

    peripheralSubsystem peripheralSubsystem_i (
        .clk,
        .rstN,
        .busReq,
        .busRsp,
        .interruptAcknowledge,
        .interruptIn,
        .interruptRequest,
        .interruptOut
    );

    task automatic reportProblem(input string what);
        $display("%s", what);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic reportMismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] expected);
        $display("FAILED %s: got 0x%h, expected 0x%h", name, got, expected);
        $display("Test failed");
        $fatal(1);
    endtask

    // enabled bytes from data, the rest kept
    function automatic logic [31:0] mergeLanes(input logic [31:0] old,
                                               input logic [31:0] data,
                                               input logic [3:0] bwe);
        logic [31:0] merged;
        merged = old;
        for (int lane = 0; lane < 4; lane++) begin
            if (bwe[lane]) begin
                merged[lane*8 +: 8] = data[lane*8 +: 8];
            end
        end
        return merged;
    endfunction

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // tests take well under 2000 cycles
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= 4000) begin
            reportProblem("timeout: run went past 4000 cycles without finishing");
        end
    end

    // every read answered two cycles later, and nothing else answered
    readLatency: assert property (@(posedge clk) disable iff (!rstN)
        busReq.read |-> ##2 busRsp.valid)
        else reportProblem("no read response two cycles after a read");
    noStrayResponse: assert property (@(posedge clk) disable iff (!rstN)
        busRsp.valid |-> $past(busReq.read, 2))
        else reportProblem("read response without a read two cycles earlier");

    // response data against the head of the queue
    always @(posedge clk) begin
        if (rstN && busRsp.valid) begin
            assert (expectedReads.size() > 0)
                else reportProblem("read response with no read outstanding");
            assert (busRsp.data == expectedReads[0])
                else reportMismatch("busRsp.data", busRsp.data, expectedReads[0]);
            void'(expectedReads.pop_front());
        end
    end

    // polls once per cycle, riseCycle is the cycle the request was seen
    task automatic waitForRequest(input int limit, output int riseCycle);
        int waited;
        waited = 0;
        while (!interruptRequest) begin
            assert (waited < limit) else reportProblem("interrupt request did not rise in time");
            @(posedge clk);
            #1;
            waited++;
        end
        riseCycle = cycleCount;
    endtask

    task automatic checkRamRoundTrip();
        int idx;
        logic [31:0] data;
        logic [3:0] bwe;
        for (int i = 0; i < 16; i++) begin
            idx = $random(seed) & 12'hfff;
            data = $random(seed);
            busWrite(regionAddress(4'd0, idx[11:0]), data, 4'hf);
            ramModel[idx] = data;
            ramIndices.push_back(idx);
        end
        // first read right behind the last write, then reads back to back
        foreach (ramIndices[i]) begin
            idx = ramIndices[i];
            busRead(regionAddress(4'd0, idx[11:0]), ramModel[idx]);
        end
        // partial lanes over words already written
        for (int i = 0; i < 8; i++) begin
            idx = ramIndices[i];
            data = $random(seed);
            bwe = $random(seed);
            ramModel[idx] = mergeLanes(ramModel[idx], data, bwe);
            busWrite(regionAddress(4'd0, idx[11:0]), data, bwe);
            busRead(regionAddress(4'd0, idx[11:0]), ramModel[idx]);
        end
        busIdle();
    endtask

    task automatic checkRandomSource();
        logic [31:0] seedValue;
        logic [31:0] state;
        seedValue = $random(seed);
        for (int pass = 0; pass < 2; pass++) begin
            // second pass seeds with zero
            if (pass == 1) begin
                seedValue = '0;
            end
            state = (seedValue == '0) ? socBusPkg::lfsrSeed : seedValue;
            busWrite(regionAddress(4'd1, 12'd0), seedValue, 4'hf);
            for (int i = 0; i < 8; i++) begin
                busRead(regionAddress(4'd1, 12'd0), state);
                state = lfsrStep(state);
            end
        end
        busIdle();
    endtask

    task automatic checkUnmappedReads();
        // a write up there must stay silent
        busWrite(regionAddress(4'd9, 12'd5), 32'hffffffff, 4'hf);
        for (int region = 3; region < 16; region += 4) begin
            busRead(regionAddress(4'(region), 12'($random(seed))), 32'h0);
        end
        busIdle();
    endtask

    task automatic checkTimerInterrupt();
        int firstRise;
        int secondRise;
        busWrite(regionAddress(4'd2, 12'd1), 32'd20, 4'hf);
        // read right behind the write sees the freshly loaded count
        busRead(regionAddress(4'd2, 12'd1), 32'd20);
        busIdle();
        waitForRequest(40, firstRise);
        assert (interruptOut == 4'd1) else reportMismatch("interruptOut", interruptOut, 32'd1);
        ackInterrupt(4'd1);
        assert (!interruptRequest) else reportProblem("interrupt request stayed high after acknowledge");
        waitForRequest(40, secondRise);
        assert (secondRise - firstRise == 20)
            else reportMismatch("interrupt period", secondRise - firstRise, 32'd20);
        ackInterrupt(4'd1);
        // stopped timer must stay quiet
        busWrite(regionAddress(4'd2, 12'd1), 32'd0, 4'hf);
        busIdle();
        repeat (60) begin
            @(posedge clk);
            #1;
            assert (!interruptRequest) else reportProblem("interrupt request after timer 1 was stopped");
        end
    endtask

    task automatic checkPriority();
        int riseCycle;
        busWrite(regionAddress(4'd2, 12'd0), 32'd30, 4'hf);
        busWrite(regionAddress(4'd2, 12'd2), 32'd33, 4'hf);
        busIdle();
        waitForRequest(50, riseCycle);
        // timer 2 fires a few cycles after timer 0
        // indices past the bank read zero while timers 0 and 2 hold live counts
        for (int k = 3; k < 8; k++) begin
            busRead(regionAddress(4'd2, 12'(k)), 32'h0);
        end
        busIdle();
        busWrite(regionAddress(4'd2, 12'd0), 32'd0, 4'hf);
        busWrite(regionAddress(4'd2, 12'd2), 32'd0, 4'hf);
        busIdle();
        assert (interruptOut == 4'd0) else reportMismatch("interruptOut", interruptOut, 32'd0);
        ackInterrupt(4'd0);
        assert (interruptRequest) else reportProblem("line 2 was lost when line 0 was acknowledged");
        assert (interruptOut == 4'd2) else reportMismatch("interruptOut", interruptOut, 32'd2);
        ackInterrupt(4'd2);
        assert (!interruptRequest) else reportProblem("interrupt request high with nothing pending");
        // stopped counts and indices past the bank all read zero
        for (int k = 0; k < 8; k++) begin
            busRead(regionAddress(4'd2, 12'(k)), 32'h0);
        end
        busIdle();
    endtask

    initial begin
        seed = 32'hd917;
        busReq = '0;
        interruptAcknowledge = 1'b0;
        interruptIn = '0;
        rstN = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        rstN = 1'b1;
        checkRamRoundTrip();
        checkRandomSource();
        checkUnmappedReads();
        checkTimerInterrupt();
        checkPriority();
        // drain the last responses
        repeat (4) busIdle();
        if (expectedReads.size() != 0) begin
            reportProblem("reads still outstanding at the end of the run");
        end else begin
            $display("Test passed");
            $finish;
        end
    end

endmodule
